/* eu_pkg.sv */
package eu_pkg;

  // number of cores served by the event unit
  localparam int NB_CORES = 4;

  // shared bus peers are the sw events, the barrier, the mutex and one buffer per core
  localparam int PEER_SW       = 0;
  localparam int PEER_BARRIER  = 1;
  localparam int PEER_MUTEX    = 2;
  localparam int PEER_BUF_BASE = 3;
  localparam int NB_PEERS      = PEER_BUF_BASE + NB_CORES;

  typedef logic [1:0]          core_id_t;
  typedef logic [NB_CORES-1:0] core_mask_t;
  typedef logic [31:0]         evt_word_t;
  typedef logic [7:0]          eu_addr_t;
  typedef logic [31:0]         eu_data_t;
  // eight software event lines per core
  typedef logic [7:0]          sw_evt_t;

  // byte offsets of the registers inside the unit
  localparam eu_addr_t REG_EVT_MASK       = 8'h00;
  localparam eu_addr_t REG_EVT_BUFFER     = 8'h04;
  localparam eu_addr_t REG_EVT_CLEAR      = 8'h08;
  localparam eu_addr_t REG_SW_TRIG        = 8'h0C;
  localparam eu_addr_t REG_BARRIER_CFG    = 8'h10;
  localparam eu_addr_t REG_BARRIER_ARRIVE = 8'h14;
  localparam eu_addr_t REG_MUTEX          = 8'h18;

  // positions of the internally generated events in a mapped word
  localparam int EVT_SW_LSB  = 0;
  localparam int EVT_BARRIER = 16;
  localparam int EVT_MUTEX   = 17;

  typedef struct packed {
    logic     psel;
    logic     penable;
    logic     pwrite;
    eu_addr_t paddr;
    eu_data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    eu_data_t prdata;
    logic     pready;
    logic     pslverr;
  } apb_rsp_t;

  // one-cycle strobe on the shared register bus
  typedef struct packed {
    logic     valid;
    logic     write;
    core_id_t core_id;
    eu_addr_t addr;
    eu_data_t wdata;
  } eu_bus_req_t;

  typedef struct packed {
    logic     hit;
    eu_data_t rdata;
  } eu_bus_rsp_t;

endpackage

/* eu_bus_arbiter.sv */
`timescale 1ns/1ps

module eu_bus_arbiter (
  input  logic                                                clk_i,
  input  logic                                                arst_n_i,
  input  eu_pkg::apb_req_t    [eu_pkg::NB_CORES-1:0]          apb_req_i,
  output eu_pkg::apb_rsp_t    [eu_pkg::NB_CORES-1:0]          apb_rsp_o,
  output eu_pkg::eu_bus_req_t                                 bus_req_o,
  input  eu_pkg::eu_bus_rsp_t [eu_pkg::NB_PEERS-1:0]          bus_rsp_i
);

  eu_pkg::core_mask_t access;
  eu_pkg::core_id_t   last_q;
  eu_pkg::core_id_t   gnt_id;
  logic               gnt_valid;
  logic               any_hit;
  eu_pkg::eu_data_t   rdata_or;

  // a core competes only while it sits in its access phase
  always_comb begin
    for (int c = 0; c < eu_pkg::NB_CORES; c++) begin
      access[c] = apb_req_i[c].psel & apb_req_i[c].penable;
    end
  end

  // search starts at the core after the one served last, so a waiting core
  // is reached before the same core can be served again
  always_comb begin
    int idx;
    gnt_valid = 1'b0;
    gnt_id    = last_q;
    for (int k = 1; k <= eu_pkg::NB_CORES; k++) begin
      idx = (int'(last_q) + k) % eu_pkg::NB_CORES;
      if (!gnt_valid && access[idx]) begin
        gnt_valid = 1'b1;
        gnt_id    = eu_pkg::core_id_t'(idx);
      end
    end
  end

  // the granted transfer goes onto the shared bus for exactly this cycle
  always_comb begin
    bus_req_o.valid   = gnt_valid;
    bus_req_o.write   = apb_req_i[gnt_id].pwrite;
    bus_req_o.core_id = gnt_id;
    bus_req_o.addr    = apb_req_i[gnt_id].paddr;
    bus_req_o.wdata   = apb_req_i[gnt_id].pwdata;
  end

  // peers drive zero when not addressed, so a plain OR merges the read data
  always_comb begin
    any_hit  = 1'b0;
    rdata_or = '0;
    for (int p = 0; p < eu_pkg::NB_PEERS; p++) begin
      any_hit  = any_hit | bus_rsp_i[p].hit;
      rdata_or = rdata_or | bus_rsp_i[p].rdata;
    end
  end

  // only the granted core sees pready, everyone else keeps waiting
  always_comb begin
    for (int c = 0; c < eu_pkg::NB_CORES; c++) begin
      apb_rsp_o[c].pready  = gnt_valid && (gnt_id == eu_pkg::core_id_t'(c));
      apb_rsp_o[c].prdata  = apb_rsp_o[c].pready ? rdata_or : '0;
      // an address that no peer claims ends with an error
      apb_rsp_o[c].pslverr = apb_rsp_o[c].pready && !any_hit;
    end
  end

  // pointer starts on the last core so that core 0 comes first after reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      last_q <= eu_pkg::core_id_t'(eu_pkg::NB_CORES - 1);
    end else if (gnt_valid) begin
      last_q <= gnt_id;
    end
  end

endmodule

/* eu_sw_events.sv */
`timescale 1ns/1ps

module eu_sw_events (
  input  logic                                          clk_i,
  input  logic                                          arst_n_i,
  input  eu_pkg::eu_bus_req_t                           bus_req_i,
  output eu_pkg::eu_bus_rsp_t                           bus_rsp_o,
  output eu_pkg::sw_evt_t [eu_pkg::NB_CORES-1:0]        sw_events_o
);

  logic                                   trig_hit;
  logic                                   trig_wr;
  eu_pkg::core_mask_t                     targets;
  logic [2:0]                             evt_num;
  eu_pkg::sw_evt_t [eu_pkg::NB_CORES-1:0] sw_events_q;

  assign trig_hit = bus_req_i.valid && (bus_req_i.addr == eu_pkg::REG_SW_TRIG);
  assign trig_wr  = trig_hit && bus_req_i.write;

  // target cores sit in the low nibble, the event number in bits 10:8
  assign targets  = bus_req_i.wdata[eu_pkg::NB_CORES-1:0];
  assign evt_num  = bus_req_i.wdata[10:8];

  // the trigger register has nothing to read back
  assign bus_rsp_o.hit   = trig_hit;
  assign bus_rsp_o.rdata = '0;

  // every pulse lasts one cycle and starts the cycle after the write
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sw_events_q <= '0;
    end else begin
      for (int c = 0; c < eu_pkg::NB_CORES; c++) begin
        sw_events_q[c] <= (trig_wr && targets[c]) ? eu_pkg::sw_evt_t'(1) << evt_num : '0;
      end
    end
  end

  assign sw_events_o = sw_events_q;

endmodule

/* eu_barrier.sv */
`timescale 1ns/1ps

module eu_barrier (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  eu_pkg::eu_bus_req_t bus_req_i,
  output eu_pkg::eu_bus_rsp_t bus_rsp_o,
  output eu_pkg::core_mask_t  barrier_events_o
);

  logic               cfg_hit;
  logic               arrive_hit;
  logic               release_now;
  eu_pkg::core_mask_t caller;
  eu_pkg::core_mask_t member_q;
  eu_pkg::core_mask_t arrived_q;
  eu_pkg::core_mask_t arrived_d;
  eu_pkg::core_mask_t release_q;

  assign cfg_hit    = bus_req_i.valid && (bus_req_i.addr == eu_pkg::REG_BARRIER_CFG);
  assign arrive_hit = bus_req_i.valid && (bus_req_i.addr == eu_pkg::REG_BARRIER_ARRIVE);
  assign caller     = eu_pkg::core_mask_t'(1) << bus_req_i.core_id;

  assign bus_rsp_o.hit = cfg_hit | arrive_hit;

  // reading the arrive offset shows who is already waiting at the barrier
  always_comb begin
    bus_rsp_o.rdata = '0;
    if (cfg_hit) begin
      bus_rsp_o.rdata = eu_pkg::eu_data_t'(member_q);
    end else if (arrive_hit) begin
      bus_rsp_o.rdata = eu_pkg::eu_data_t'(arrived_q);
    end
  end

  // an arrival counts only when the caller is a member
  assign arrived_d   = (arrive_hit && bus_req_i.write && |(member_q & caller)) ?
                       (arrived_q | caller) : arrived_q;
  assign release_now = (member_q != '0) && (arrived_d == member_q);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      member_q  <= '0;
      arrived_q <= '0;
      release_q <= '0;
    end else begin
      // all members are woken together in the cycle after the last arrival
      release_q <= release_now ? member_q : '0;
      if (cfg_hit && bus_req_i.write) begin
        // a new membership starts a fresh round
        member_q  <= bus_req_i.wdata[eu_pkg::NB_CORES-1:0];
        arrived_q <= '0;
      end else if (release_now) begin
        arrived_q <= '0;
      end else begin
        arrived_q <= arrived_d;
      end
    end
  end

  assign barrier_events_o = release_q;

endmodule

/* eu_mutex.sv */
`timescale 1ns/1ps

module eu_mutex (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  eu_pkg::eu_bus_req_t bus_req_i,
  output eu_pkg::eu_bus_rsp_t bus_rsp_o,
  output eu_pkg::core_mask_t  mutex_events_o
);

  logic               lock_hit;
  logic               lock_rd;
  logic               unlock;
  logic               locked_q;
  eu_pkg::core_id_t   owner_q;
  eu_pkg::core_mask_t caller;
  eu_pkg::core_mask_t waiters_q;
  eu_pkg::core_mask_t mutex_events_q;

  assign lock_hit = bus_req_i.valid && (bus_req_i.addr == eu_pkg::REG_MUTEX);
  assign lock_rd  = lock_hit && !bus_req_i.write;
  assign caller   = eu_pkg::core_mask_t'(1) << bus_req_i.core_id;

  // only the current owner can give the lock back
  assign unlock = lock_hit && bus_req_i.write && locked_q && (owner_q == bus_req_i.core_id);

  // a read returns 1 when it took the lock and 0 when the lock was busy
  assign bus_rsp_o.hit   = lock_hit;
  assign bus_rsp_o.rdata = eu_pkg::eu_data_t'(lock_rd && !locked_q);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      locked_q       <= 1'b0;
      owner_q        <= '0;
      waiters_q      <= '0;
      mutex_events_q <= '0;
    end else begin
      mutex_events_q <= '0;
      if (lock_rd) begin
        if (!locked_q) begin
          locked_q <= 1'b1;
          owner_q  <= bus_req_i.core_id;
        end else begin
          // a failed attempt is remembered so the core gets woken on release
          waiters_q <= waiters_q | caller;
        end
      end else if (unlock) begin
        locked_q       <= 1'b0;
        mutex_events_q <= waiters_q;
        waiters_q      <= '0;
      end
    end
  end

  assign mutex_events_o = mutex_events_q;

endmodule

/* cluster_event_map.sv */
`timescale 1ns/1ps

module cluster_event_map (
  // events produced inside the unit
  input  eu_pkg::sw_evt_t   [eu_pkg::NB_CORES-1:0]        sw_events_i,
  input  eu_pkg::core_mask_t                              barrier_events_i,
  input  eu_pkg::core_mask_t                              mutex_events_i,
  input  logic                                            periph_fifo_event_i,

  // events coming from the rest of the cluster
  input  logic              [eu_pkg::NB_CORES-1:0][3:0]   acc_events_i,
  input  logic              [eu_pkg::NB_CORES-1:0][1:0]   dma_events_i,
  input  logic              [eu_pkg::NB_CORES-1:0][1:0]   timer_events_i,
  input  logic              [eu_pkg::NB_CORES-1:0][31:0]  cluster_events_i,
  input  logic                                            decompr_done_evt_i,

  output eu_pkg::evt_word_t [eu_pkg::NB_CORES-1:0]        events_mapped_o
);

  for (genvar i = 0; i < eu_pkg::NB_CORES; i++) begin : g_map
    eu_pkg::evt_word_t word;

    // unused positions and the old dispatch slot at bit 18 stay zero
    always_comb begin
      word = '0;
      // shared lines go to every core
      word[27]    = periph_fifo_event_i;
      word[24]    = decompr_done_evt_i;
      // only the two low cluster event lines are visible to software
      word[23:22] = cluster_events_i[i][1:0];
      word[eu_pkg::EVT_MUTEX]   = mutex_events_i[i];
      word[eu_pkg::EVT_BARRIER] = barrier_events_i[i];
      word[15:12] = acc_events_i[i];
      word[11:10] = timer_events_i[i];
      word[9:8]   = dma_events_i[i];
      word[eu_pkg::EVT_SW_LSB +: 8] = sw_events_i[i];
    end

    assign events_mapped_o[i] = word;
  end

endmodule

/* eu_core_event_buf.sv */
`timescale 1ns/1ps

module eu_core_event_buf #(
  // core whose bus cycles this buffer answers
  parameter int unsigned CORE_ID = 0
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  eu_pkg::eu_bus_req_t bus_req_i,
  output eu_pkg::eu_bus_rsp_t bus_rsp_o,
  input  eu_pkg::evt_word_t   events_i,
  output logic                wake_o
);

  logic              mine;
  logic              mask_hit;
  logic              buf_hit;
  logic              clr_hit;
  eu_pkg::evt_word_t clr_bits;
  eu_pkg::evt_word_t mask_q;
  eu_pkg::evt_word_t buf_q;

  // every core sees its own registers at the same offsets
  assign mine     = bus_req_i.valid && (bus_req_i.core_id == eu_pkg::core_id_t'(CORE_ID));
  assign mask_hit = mine && (bus_req_i.addr == eu_pkg::REG_EVT_MASK);
  assign buf_hit  = mine && (bus_req_i.addr == eu_pkg::REG_EVT_BUFFER);
  assign clr_hit  = mine && (bus_req_i.addr == eu_pkg::REG_EVT_CLEAR);

  assign bus_rsp_o.hit = mask_hit | buf_hit | clr_hit;

  // the clear register reads as zero and the buffer ignores writes
  always_comb begin
    bus_rsp_o.rdata = '0;
    if (mask_hit) begin
      bus_rsp_o.rdata = mask_q;
    end else if (buf_hit) begin
      bus_rsp_o.rdata = buf_q;
    end
  end

  assign clr_bits = (clr_hit && bus_req_i.write) ? bus_req_i.wdata : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mask_q <= '0;
      buf_q  <= '0;
    end else begin
      if (mask_hit && bus_req_i.write) begin
        mask_q <= bus_req_i.wdata;
      end
      // clear goes first so an event arriving in the same cycle is kept
      buf_q <= (buf_q & ~clr_bits) | events_i;
    end
  end

  // any pending event that software has enabled wakes the core
  assign wake_o = |(buf_q & mask_q);

endmodule

/* event_unit_top.sv */
`timescale 1ns/1ps

module event_unit_top (
  input  logic                                            clk_i,
  input  logic                                            arst_n_i,

  // one APB port per core
  input  eu_pkg::apb_req_t  [eu_pkg::NB_CORES-1:0]        apb_req_i,
  output eu_pkg::apb_rsp_t  [eu_pkg::NB_CORES-1:0]        apb_rsp_o,

  // external event sources
  input  logic                                            periph_fifo_event_i,
  input  logic              [eu_pkg::NB_CORES-1:0][3:0]   acc_events_i,
  input  logic              [eu_pkg::NB_CORES-1:0][1:0]   dma_events_i,
  input  logic              [eu_pkg::NB_CORES-1:0][1:0]   timer_events_i,
  input  logic              [eu_pkg::NB_CORES-1:0][31:0]  cluster_events_i,
  input  logic                                            decompr_done_evt_i,

  output eu_pkg::core_mask_t                              wake_o
);

  eu_pkg::eu_bus_req_t                          bus_req;
  eu_pkg::eu_bus_rsp_t [eu_pkg::NB_PEERS-1:0]   bus_rsp;
  eu_pkg::sw_evt_t     [eu_pkg::NB_CORES-1:0]   sw_events;
  eu_pkg::core_mask_t                           barrier_events;
  eu_pkg::core_mask_t                           mutex_events;
  eu_pkg::evt_word_t   [eu_pkg::NB_CORES-1:0]   events_mapped;

  // the arbiter owns the shared register bus
  eu_bus_arbiter i_arbiter (
    .clk_i     ( clk_i     ),
    .arst_n_i  ( arst_n_i  ),
    .apb_req_i ( apb_req_i ),
    .apb_rsp_o ( apb_rsp_o ),
    .bus_req_o ( bus_req   ),
    .bus_rsp_i ( bus_rsp   )
  );

  eu_sw_events i_sw_events (
    .clk_i       ( clk_i                    ),
    .arst_n_i    ( arst_n_i                 ),
    .bus_req_i   ( bus_req                  ),
    .bus_rsp_o   ( bus_rsp[eu_pkg::PEER_SW] ),
    .sw_events_o ( sw_events                )
  );

  eu_barrier i_barrier (
    .clk_i            ( clk_i                         ),
    .arst_n_i         ( arst_n_i                      ),
    .bus_req_i        ( bus_req                       ),
    .bus_rsp_o        ( bus_rsp[eu_pkg::PEER_BARRIER] ),
    .barrier_events_o ( barrier_events                )
  );

  eu_mutex i_mutex (
    .clk_i          ( clk_i                       ),
    .arst_n_i       ( arst_n_i                    ),
    .bus_req_i      ( bus_req                     ),
    .bus_rsp_o      ( bus_rsp[eu_pkg::PEER_MUTEX] ),
    .mutex_events_o ( mutex_events                )
  );

  cluster_event_map i_event_map (
    .sw_events_i         ( sw_events           ),
    .barrier_events_i    ( barrier_events      ),
    .mutex_events_i      ( mutex_events        ),
    .periph_fifo_event_i ( periph_fifo_event_i ),
    .acc_events_i        ( acc_events_i        ),
    .dma_events_i        ( dma_events_i        ),
    .timer_events_i      ( timer_events_i      ),
    .cluster_events_i    ( cluster_events_i    ),
    .decompr_done_evt_i  ( decompr_done_evt_i  ),
    .events_mapped_o     ( events_mapped       )
  );

  // one event buffer per core, each answering only its own core id
  for (genvar i = 0; i < eu_pkg::NB_CORES; i++) begin : g_core_buf
    eu_core_event_buf #(
      .CORE_ID ( i )
    ) i_event_buf (
      .clk_i     ( clk_i                                ),
      .arst_n_i  ( arst_n_i                             ),
      .bus_req_i ( bus_req                              ),
      .bus_rsp_o ( bus_rsp[eu_pkg::PEER_BUF_BASE + i]   ),
      .events_i  ( events_mapped[i]                     ),
      .wake_o    ( wake_o[i]                            )
    );
  end

endmodule

/* eu_tb.sv */
`timescale 1ns/1ps

module eu_tb;

  // budget per test plus some margin for contention
  localparam int TEST_COUNT      = 6;
  localparam int CYCLES_PER_TEST = 60;
  localparam int WATCHDOG_CYCLES = TEST_COUNT * CYCLES_PER_TEST + 40;

  logic                                           clk;
  logic                                           arst_n;
  eu_pkg::apb_req_t   [eu_pkg::NB_CORES-1:0]      apb_req;
  eu_pkg::apb_rsp_t   [eu_pkg::NB_CORES-1:0]      apb_rsp;
  logic                                           periph_fifo;
  logic               [eu_pkg::NB_CORES-1:0][3:0] acc_ev;
  logic               [eu_pkg::NB_CORES-1:0][1:0] dma_ev;
  logic               [eu_pkg::NB_CORES-1:0][1:0] timer_ev;
  logic               [eu_pkg::NB_CORES-1:0][31:0] cluster_ev;
  logic                                           decompr_done;
  eu_pkg::core_mask_t                             wake;

  // copies of the external patterns, kept after the inputs are released
  logic               [eu_pkg::NB_CORES-1:0][3:0] acc_pat;
  logic               [eu_pkg::NB_CORES-1:0][1:0] dma_pat;
  logic               [eu_pkg::NB_CORES-1:0][1:0] timer_pat;
  logic               [eu_pkg::NB_CORES-1:0][31:0] cluster_pat;

  int seed;
  int err_count;
  int fair_errs = 0;

  // cores still waiting when a core was last served, and who got served since
  eu_pkg::core_mask_t pending [eu_pkg::NB_CORES] = '{default: '0};
  eu_pkg::core_mask_t served  [eu_pkg::NB_CORES] = '{default: '0};
  eu_pkg::core_mask_t access_now;

  event_unit_top uut (
    .clk_i               ( clk          ),
    .arst_n_i            ( arst_n       ),
    .apb_req_i           ( apb_req      ),
    .apb_rsp_o           ( apb_rsp      ),
    .periph_fifo_event_i ( periph_fifo  ),
    .acc_events_i        ( acc_ev       ),
    .dma_events_i        ( dma_ev       ),
    .timer_events_i      ( timer_ev     ),
    .cluster_events_i    ( cluster_ev   ),
    .decompr_done_evt_i  ( decompr_done ),
    .wake_o              ( wake         )
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // a core that waited must be served before the served core comes back
  always @(negedge clk) begin
    for (int c = 0; c < eu_pkg::NB_CORES; c++) begin
      access_now[c] = apb_req[c].psel & apb_req[c].penable;
    end
    for (int c = 0; c < eu_pkg::NB_CORES; c++) begin
      if (apb_rsp[c].pready) begin
        if ((pending[c] & ~served[c]) != '0) begin
          $display("core %0d was served twice while another core kept waiting at %0t",
                   c, $time);
          fair_errs++;
        end
        pending[c] = access_now & ~(eu_pkg::core_mask_t'(1) << c);
        served[c]  = '0;
        for (int o = 0; o < eu_pkg::NB_CORES; o++) begin
          if (o != c) begin
            served[o] = served[o] | (eu_pkg::core_mask_t'(1) << c);
          end
        end
      end
    end
  end

  task automatic compare_value(input string name, input eu_pkg::eu_data_t expected,
                               input eu_pkg::eu_data_t actual);
    if (expected !== actual) begin
      $display("ERR %0t %s expected 0x%08h actual 0x%08h", $time, name, expected, actual);
      err_count++;
    end
  endtask

  // setup phase first, then access until pready, response taken at the falling edge
  task automatic run_transfer(input int core, input logic write, input eu_pkg::eu_addr_t addr,
                              input eu_pkg::eu_data_t wdata, output eu_pkg::eu_data_t rdata,
                              output logic err);
    logic done;
    done  = 1'b0;
    rdata = '0;
    err   = 1'b0;
    apb_req[core].psel    = 1'b1;
    apb_req[core].penable = 1'b0;
    apb_req[core].pwrite  = write;
    apb_req[core].paddr   = addr;
    apb_req[core].pwdata  = wdata;
    @(posedge clk);
    #1;
    apb_req[core].penable = 1'b1;
    while (!done) begin
      @(negedge clk);
      if (apb_rsp[core].pready) begin
        rdata = apb_rsp[core].prdata;
        err   = apb_rsp[core].pslverr;
        done  = 1'b1;
      end
      @(posedge clk);
      #1;
    end
    apb_req[core].psel    = 1'b0;
    apb_req[core].penable = 1'b0;
  endtask

  task automatic apb_write(input int core, input eu_pkg::eu_addr_t addr,
                           input eu_pkg::eu_data_t data);
    eu_pkg::eu_data_t unused_rd;
    logic err;
    run_transfer(core, 1'b1, addr, data, unused_rd, err);
    compare_value($sformatf("core%0d pslverr", core), '0, eu_pkg::eu_data_t'(err));
  endtask

  task automatic apb_read(input int core, input eu_pkg::eu_addr_t addr,
                          output eu_pkg::eu_data_t data);
    logic err;
    run_transfer(core, 1'b0, addr, '0, data, err);
    compare_value($sformatf("core%0d pslverr", core), '0, eu_pkg::eu_data_t'(err));
  endtask

  task automatic expect_read(input int core, input eu_pkg::eu_addr_t addr,
                             input eu_pkg::eu_data_t expected, input string name);
    eu_pkg::eu_data_t rd;
    apb_read(core, addr, rd);
    compare_value($sformatf("core%0d %s", core, name), expected, rd);
  endtask

  // wake_o only depends on registers, so the falling edge sees it settled
  task automatic expect_wake(input eu_pkg::core_mask_t expected);
    @(negedge clk);
    compare_value("wake_o", eu_pkg::eu_data_t'(expected), eu_pkg::eu_data_t'(wake));
    @(posedge clk);
    #1;
  endtask

  task automatic clear_buffers();
    for (int c = 0; c < eu_pkg::NB_CORES; c++) begin
      apb_write(c, eu_pkg::REG_EVT_CLEAR, 32'hFFFF_FFFF);
    end
  endtask

  task automatic reset_and_decode();
    eu_pkg::eu_data_t rd;
    logic err;
    for (int c = 0; c < eu_pkg::NB_CORES; c++) begin
      expect_read(c, eu_pkg::REG_EVT_MASK, '0, "mask");
      expect_read(c, eu_pkg::REG_EVT_BUFFER, '0, "buffer");
    end
    expect_wake('0);
    // nothing lives at 0x40, so the transfer has to end in an error
    run_transfer(0, 1'b0, 8'h40, '0, rd, err);
    compare_value("core0 pslverr at 0x40", 32'h1, eu_pkg::eu_data_t'(err));
  endtask

  task automatic sw_event_trigger();
    int n;
    eu_pkg::eu_data_t bit_n;
    n     = $unsigned($random(seed)) % 8;
    bit_n = eu_pkg::eu_data_t'(1) << (eu_pkg::EVT_SW_LSB + n);
    // target cores 1 and 2 with event number n
    apb_write(0, eu_pkg::REG_SW_TRIG, (eu_pkg::eu_data_t'(n) << 8) | 32'h0000_0006);
    for (int c = 0; c < eu_pkg::NB_CORES; c++) begin
      expect_read(c, eu_pkg::REG_EVT_BUFFER, (c == 1 || c == 2) ? bit_n : 32'h0, "buffer");
    end
    apb_write(1, eu_pkg::REG_EVT_MASK, bit_n);
    expect_wake(4'b0010);
    apb_write(1, eu_pkg::REG_EVT_CLEAR, bit_n);
    expect_wake('0);
    expect_read(1, eu_pkg::REG_EVT_BUFFER, '0, "buffer after clear");
  endtask

  task automatic barrier_release();
    eu_pkg::eu_data_t bar_bit;
    bar_bit = eu_pkg::eu_data_t'(1) << eu_pkg::EVT_BARRIER;
    clear_buffers();
    apb_write(0, eu_pkg::REG_BARRIER_CFG, 32'h0000_0007);
    apb_write(0, eu_pkg::REG_BARRIER_ARRIVE, '0);
    apb_write(1, eu_pkg::REG_BARRIER_ARRIVE, '0);
    for (int c = 0; c < eu_pkg::NB_CORES; c++) begin
      expect_read(c, eu_pkg::REG_EVT_BUFFER, '0, "buffer before release");
    end
    // core 3 is not a member and must not complete the barrier
    apb_write(3, eu_pkg::REG_BARRIER_ARRIVE, '0);
    for (int c = 0; c < eu_pkg::NB_CORES; c++) begin
      expect_read(c, eu_pkg::REG_EVT_BUFFER, '0, "buffer after non-member");
    end
    apb_write(2, eu_pkg::REG_BARRIER_ARRIVE, '0);
    for (int c = 0; c < eu_pkg::NB_CORES; c++) begin
      expect_read(c, eu_pkg::REG_EVT_BUFFER, (c < 3) ? bar_bit : 32'h0, "buffer after release");
    end
  endtask

  task automatic mutex_handoff();
    eu_pkg::eu_data_t mtx_bit;
    mtx_bit = eu_pkg::eu_data_t'(1) << eu_pkg::EVT_MUTEX;
    clear_buffers();
    expect_read(0, eu_pkg::REG_MUTEX, 32'h1, "lock");
    expect_read(1, eu_pkg::REG_MUTEX, 32'h0, "lock");
    // core 1 does not own the lock
    apb_write(1, eu_pkg::REG_MUTEX, '0);
    expect_read(2, eu_pkg::REG_MUTEX, 32'h0, "lock");
    apb_write(0, eu_pkg::REG_MUTEX, '0);
    for (int c = 0; c < eu_pkg::NB_CORES; c++) begin
      expect_read(c, eu_pkg::REG_EVT_BUFFER, (c == 1 || c == 2) ? mtx_bit : 32'h0, "buffer");
    end
    expect_read(1, eu_pkg::REG_MUTEX, 32'h1, "lock after release");
    apb_write(1, eu_pkg::REG_MUTEX, '0);
  endtask

  // expected word built from the placement table of the event map
  function automatic eu_pkg::evt_word_t mapped_word(input int c);
    eu_pkg::evt_word_t w;
    w = eu_pkg::evt_word_t'(1) << 27;
    w = w | (eu_pkg::evt_word_t'(1) << 24);
    w = w | (eu_pkg::evt_word_t'(cluster_pat[c][1:0]) << 22);
    w = w | (eu_pkg::evt_word_t'(acc_pat[c]) << 12);
    w = w | (eu_pkg::evt_word_t'(timer_pat[c]) << 10);
    w = w | (eu_pkg::evt_word_t'(dma_pat[c]) << 8);
    return w;
  endfunction

  task automatic external_event_map();
    clear_buffers();
    for (int c = 0; c < eu_pkg::NB_CORES; c++) begin
      acc_pat[c]     = 4'(c * 3 + 5);
      dma_pat[c]     = 2'(c);
      timer_pat[c]   = 2'(3 - c);
      // upper cluster bits are set on purpose, they must not show up
      cluster_pat[c] = 32'h1234_5670 + 32'(c);
    end
    acc_ev       = acc_pat;
    dma_ev       = dma_pat;
    timer_ev     = timer_pat;
    cluster_ev   = cluster_pat;
    periph_fifo  = 1'b1;
    decompr_done = 1'b1;
    @(posedge clk);
    #1;
    acc_ev       = '0;
    dma_ev       = '0;
    timer_ev     = '0;
    cluster_ev   = '0;
    periph_fifo  = 1'b0;
    decompr_done = 1'b0;
    for (int c = 0; c < eu_pkg::NB_CORES; c++) begin
      expect_read(c, eu_pkg::REG_EVT_BUFFER, mapped_word(c), "mapped buffer");
    end
  endtask

  task automatic contended_access();
    eu_pkg::eu_data_t masks [eu_pkg::NB_CORES];
    eu_pkg::eu_data_t rd    [eu_pkg::NB_CORES];
    for (int c = 0; c < eu_pkg::NB_CORES; c++) begin
      masks[c] = $random(seed);
    end
    // all four cores start in the same cycle and each goes straight from its
    // write into its read, so a served core competes again while others still wait
    fork
      begin
        apb_write(0, eu_pkg::REG_EVT_MASK, masks[0]);
        apb_read(0, eu_pkg::REG_EVT_MASK, rd[0]);
      end
      begin
        apb_write(1, eu_pkg::REG_EVT_MASK, masks[1]);
        apb_read(1, eu_pkg::REG_EVT_MASK, rd[1]);
      end
      begin
        apb_write(2, eu_pkg::REG_EVT_MASK, masks[2]);
        apb_read(2, eu_pkg::REG_EVT_MASK, rd[2]);
      end
      begin
        apb_write(3, eu_pkg::REG_EVT_MASK, masks[3]);
        apb_read(3, eu_pkg::REG_EVT_MASK, rd[3]);
      end
    join
    for (int c = 0; c < eu_pkg::NB_CORES; c++) begin
      compare_value($sformatf("core%0d contended mask", c), masks[c], rd[c]);
    end
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    seed         = 49404;
    err_count    = 0;
    arst_n       = 1'b0;
    apb_req      = '0;
    periph_fifo  = 1'b0;
    acc_ev       = '0;
    dma_ev       = '0;
    timer_ev     = '0;
    cluster_ev   = '0;
    decompr_done = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;
    reset_and_decode();
    sw_event_trigger();
    barrier_release();
    mutex_handoff();
    external_event_map();
    contended_access();
    $display("check errors: %0d, arbitration errors: %0d", err_count, fair_errs);
    if (err_count == 0 && fair_errs == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* sources.f */
eu_pkg.sv
eu_bus_arbiter.sv
eu_sw_events.sv
eu_barrier.sv
eu_mutex.sv
cluster_event_map.sv
eu_core_event_buf.sv
event_unit_top.sv
eu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the event unit testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module eu_tb -f sources.f -o eu_sim
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/eu_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "Finished with no errors" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
